/* common/rename_params.svh */
/*
 * Rename subsystem parameters
 * Group width, register file sizes and active-list depth
 */
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Ops renamed per cycle
`define RENAME_WIDTH 2

// Architectural and physical register counts
`define LOG_REG_NUM 16
`define PHY_REG_NUM 32

// In-flight ops tracked for commit
`define ACTIVE_LIST_DEPTH 16

`endif

/* common/RenameTypes.sv */
/*
 * Rename types
 * Register numbers, pointers, decoded op and active-list entry layouts,
 * and the serializer phase encoding
 */
`include "rename_params.svh"

package RenameTypes;

    typedef logic [$clog2(`LOG_REG_NUM)-1:0] LogRegNum;
    typedef logic [$clog2(`PHY_REG_NUM)-1:0] PhyRegNum;
    typedef logic [$clog2(`ACTIVE_LIST_DEPTH)-1:0] ActiveListPtr;

    // One extra bit so a full queue can be counted
    typedef logic [$clog2(`PHY_REG_NUM):0] FreeListCount;

    // Decoded op as seen by rename
    typedef struct packed {
        LogRegNum srcRegA;
        LogRegNum srcRegB;
        LogRegNum dstReg;
        logic readRegA;
        logic readRegB;
        logic writeReg;
        logic serialized;
        logic fence;
    } OpInfo;

    typedef struct packed {
        LogRegNum logDstReg;
        PhyRegNum phyDstReg;
        PhyRegNum phyPrevDstReg;
    } ActiveListEntry;

    // Serializer state
    typedef enum logic [1:0] {
        phaseNormal = 2'd0,
        phaseWaitOwn = 2'd2
    } SerializePhase;

endpackage

/* common/RenameLogicIF.sv */
/*
 * Rename logic interface
 * Logical numbers from the stage, physical numbers back from the map table
 */
`timescale 1ns/100ps
`include "rename_params.svh"

interface RenameLogicIF;

    // Per slot, from the stage
    logic [`RENAME_WIDTH-1:0] update;
    RenameTypes::LogRegNum [`RENAME_WIDTH-1:0] logSrcA;
    RenameTypes::LogRegNum [`RENAME_WIDTH-1:0] logSrcB;
    RenameTypes::LogRegNum [`RENAME_WIDTH-1:0] logDst;
    logic [`RENAME_WIDTH-1:0] writeReg;

    // Per slot, renamed
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] phySrcA;
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] phySrcB;
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] phyDst;
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] phyPrevDst;
    logic allocatable;

    modport stage (
        output update, logSrcA, logSrcB, logDst, writeReg,
        input phySrcA, phySrcB, phyDst, phyPrevDst, allocatable
    );

    modport renameLogic (
        input update, logSrcA, logSrcB, logDst, writeReg,
        output phySrcA, phySrcB, phyDst, phyPrevDst, allocatable
    );

endinterface

/* rename/RenameStageSerializer.sv */
/*
 * Rename serializer
 * Holds a serialized op until all older ops commit (a fence also waits
 * for the store queue), then holds younger ops until it commits itself
 */
`timescale 1ns/100ps
`include "rename_params.svh"

module RenameStageSerializer (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic clear,
    input  logic activeListEmpty,
    input  logic storeQueueEmpty,
    input  RenameTypes::OpInfo [`RENAME_WIDTH-1:0] op,
    input  logic [`RENAME_WIDTH-1:0] valid,
    output logic serialize
);

    RenameTypes::SerializePhase phase;
    RenameTypes::SerializePhase nextPhase;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            phase <= RenameTypes::phaseNormal;
        end else if (!stall) begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        serialize = 1'b0;
        nextPhase = RenameTypes::phaseNormal;
        if (phase == RenameTypes::phaseWaitOwn && (!activeListEmpty || !storeQueueEmpty)) begin
            // Serialized op still in flight
            serialize = 1'b1;
            nextPhase = RenameTypes::phaseWaitOwn;
        end else if (valid[0] && op[0].serialized) begin
            if (!activeListEmpty || (op[0].fence && !storeQueueEmpty)) begin
                serialize = 1'b1;
            end else begin
                // Op leaves this cycle
                nextPhase = RenameTypes::phaseWaitOwn;
            end
        end
    end

    // Decode sends a serialized op only alone in slot 0
    for (genvar i = 1; i < `RENAME_WIDTH; i++) begin : gSlotCheck
        assert property (@(posedge clk) disable iff (rst) !(valid[i] && op[i].serialized))
            else $error("Serialized op in slot %0d", i);
    end

endmodule

/* rename/FreeList.sv */
/*
 * Free list
 * Circular queue of free physical registers; pops up to two per cycle
 * at the head and takes one released register per cycle at the tail
 */
`timescale 1ns/100ps
`include "rename_params.svh"

module FreeList (
    input  logic clk,
    input  logic rst,
    input  logic [1:0] popCount,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] popReg,
    output RenameTypes::FreeListCount freeCount,
    input  logic pushValid,
    input  RenameTypes::PhyRegNum pushReg
);

    // Registers not mapped at reset
    localparam int Depth = `PHY_REG_NUM - `LOG_REG_NUM;
    localparam int PtrWidth = $clog2(Depth);

    RenameTypes::PhyRegNum queue [Depth];
    logic [PtrWidth-1:0] head;
    logic [PtrWidth-1:0] tail;

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            popReg[i] = queue[head + PtrWidth'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Starts full, ascending from the first unmapped register
            for (int i = 0; i < Depth; i++) begin
                queue[i] <= RenameTypes::PhyRegNum'(`LOG_REG_NUM + i);
            end
            head <= '0;
            tail <= '0;
            freeCount <= RenameTypes::FreeListCount'(Depth);
        end else begin
            if (pushValid) begin
                queue[tail] <= pushReg;
                tail <= tail + PtrWidth'(1);
            end
            head <= head + PtrWidth'(popCount);
            freeCount <= freeCount + RenameTypes::FreeListCount'(pushValid)
                         - RenameTypes::FreeListCount'(popCount);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        RenameTypes::FreeListCount'(popCount) <= freeCount)
        else $error("Free list popped beyond occupancy");

endmodule

/* rename/RenameLogic.sv */
/*
 * Rename logic
 * Register map table with in-group dependency bypass; new destinations
 * come from the free list
 */
`timescale 1ns/100ps
`include "rename_params.svh"

module RenameLogic (
    input  logic clk,
    input  logic rst,
    RenameLogicIF.renameLogic rn,
    input  logic releaseValid,
    input  RenameTypes::PhyRegNum releaseReg
);

    RenameTypes::PhyRegNum mapTable [`LOG_REG_NUM];
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] popReg;
    RenameTypes::FreeListCount freeCount;
    RenameTypes::PhyRegNum slot0Dst;
    logic [1:0] popCount;
    logic [1:0] writeCount;

    FreeList freeList (
        .clk(clk),
        .rst(rst),
        .popCount(popCount),
        .popReg(popReg),
        .freeCount(freeCount),
        .pushValid(releaseValid),
        .pushReg(releaseReg)
    );

    always_comb begin
        writeCount = '0;
        popCount = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            writeCount = writeCount + 2'(rn.writeReg[i]);
            popCount = popCount + 2'(rn.update[i] && rn.writeReg[i]);
        end
        rn.allocatable = freeCount >= RenameTypes::FreeListCount'(writeCount);

        // Slot 0 reads the table as is
        slot0Dst = rn.writeReg[0] ? popReg[0] : mapTable[rn.logDst[0]];
        rn.phySrcA[0] = mapTable[rn.logSrcA[0]];
        rn.phySrcB[0] = mapTable[rn.logSrcB[0]];
        rn.phyPrevDst[0] = mapTable[rn.logDst[0]];
        rn.phyDst[0] = slot0Dst;

        // Slot 1 sees slot 0's new mapping
        rn.phySrcA[1] = (rn.writeReg[0] && rn.logSrcA[1] == rn.logDst[0]) ?
                        slot0Dst : mapTable[rn.logSrcA[1]];
        rn.phySrcB[1] = (rn.writeReg[0] && rn.logSrcB[1] == rn.logDst[0]) ?
                        slot0Dst : mapTable[rn.logSrcB[1]];
        rn.phyPrevDst[1] = (rn.writeReg[0] && rn.logDst[1] == rn.logDst[0]) ?
                           slot0Dst : mapTable[rn.logDst[1]];
        rn.phyDst[1] = rn.writeReg[1] ? popReg[rn.writeReg[0]] : rn.phyPrevDst[1];
    end

    // Later slot wins on the same logical register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LOG_REG_NUM; i++) begin
                mapTable[i] <= RenameTypes::PhyRegNum'(i);
            end
        end else begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (rn.update[i] && rn.writeReg[i]) begin
                    mapTable[rn.logDst[i]] <= rn.phyDst[i];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !((|(rn.update & rn.writeReg)) && !rn.allocatable))
        else $error("Register allocated without free registers");

endmodule

/* rename/RenameStage.sv */
/*
 * Rename stage
 * Holds one group of decoded ops, renames it through the map table,
 * builds the active-list entries and stalls on resources or serialization
 */
`timescale 1ns/100ps
`include "rename_params.svh"

module RenameStage (
    input  logic clk,
    input  logic rst,
    input  logic [`RENAME_WIDTH-1:0] inValid,
    input  RenameTypes::OpInfo [`RENAME_WIDTH-1:0] inOp,
    input  logic stall,
    input  logic clear,
    RenameLogicIF.stage rn,
    input  logic alAllocatable,
    input  logic alEmpty,
    input  RenameTypes::ActiveListPtr [`RENAME_WIDTH-1:0] alPushedPtr,
    input  logic storeQueueEmpty,
    output logic [`RENAME_WIDTH-1:0] pushTail,
    output RenameTypes::ActiveListEntry [`RENAME_WIDTH-1:0] pushData,
    output logic ready,
    output logic [`RENAME_WIDTH-1:0] outValid,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhySrcA,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhySrcB,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhyDst,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhyPrevDst,
    output RenameTypes::ActiveListPtr [`RENAME_WIDTH-1:0] outActiveListPtr
);

    logic [`RENAME_WIDTH-1:0] valid;
    RenameTypes::OpInfo [`RENAME_WIDTH-1:0] op;
    logic [`RENAME_WIDTH-1:0] update;
    logic serialize;
    logic stageStall;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid <= '0;
        end else if (!stageStall) begin
            valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stageStall) begin
            op <= inOp;
        end
    end

    // Resource check only matters with something in the register
    assign stageStall = stall || serialize ||
                        ((|valid) && (!rn.allocatable || !alAllocatable));
    assign ready = !stageStall;

    RenameStageSerializer serializer (
        .clk(clk),
        .rst(rst),
        .stall(stageStall),
        .clear(clear),
        .activeListEmpty(alEmpty),
        .storeQueueEmpty(storeQueueEmpty),
        .op(op),
        .valid(valid),
        .serialize(serialize)
    );

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            update[i] = valid[i] && !stageStall && !clear;

            // Map table request; writes counted only for valid slots
            rn.update[i] = update[i];
            rn.logSrcA[i] = op[i].srcRegA;
            rn.logSrcB[i] = op[i].srcRegB;
            rn.logDst[i] = op[i].dstReg;
            rn.writeReg[i] = valid[i] && op[i].writeReg;

            // A non-writing op carries equal new and previous numbers,
            // which the active list reads as "nothing to release"
            pushTail[i] = update[i];
            pushData[i].logDstReg = op[i].dstReg;
            pushData[i].phyDstReg = rn.phyDst[i];
            pushData[i].phyPrevDstReg = rn.phyPrevDst[i];

            outValid[i] = update[i];
            // Unread sources show as register 0
            outPhySrcA[i] = op[i].readRegA ? rn.phySrcA[i] : '0;
            outPhySrcB[i] = op[i].readRegB ? rn.phySrcB[i] : '0;
            outPhyDst[i] = rn.phyDst[i];
            outPhyPrevDst[i] = rn.phyPrevDst[i];
            outActiveListPtr[i] = alPushedPtr[i];
        end
    end

endmodule

/* logic/ActiveList.sv */
/*
 * Active list
 * In-order buffer of renamed ops; filled at rename, drained one entry
 * per commit pulse, returning the previous destination to the free list
 */
`timescale 1ns/100ps
`include "rename_params.svh"

module ActiveList (
    input  logic clk,
    input  logic rst,
    input  logic [`RENAME_WIDTH-1:0] pushTail,
    input  RenameTypes::ActiveListEntry [`RENAME_WIDTH-1:0] pushData,
    output RenameTypes::ActiveListPtr [`RENAME_WIDTH-1:0] pushedPtr,
    output logic allocatable,
    output logic empty,
    input  logic commit,
    output logic releaseValid,
    output RenameTypes::PhyRegNum releaseReg
);

    localparam int Depth = `ACTIVE_LIST_DEPTH;
    localparam int CountWidth = $clog2(Depth) + 1;

    RenameTypes::ActiveListEntry entries [Depth];
    logic wrote [Depth];
    RenameTypes::ActiveListPtr head;
    RenameTypes::ActiveListPtr tail;
    logic [CountWidth-1:0] count;
    logic [1:0] pushCount;
    logic popValid;

    always_comb begin
        RenameTypes::ActiveListPtr ptr;
        ptr = tail;
        pushCount = '0;
        // Valid slots take consecutive entries
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            pushedPtr[i] = ptr;
            if (pushTail[i]) begin
                ptr = ptr + RenameTypes::ActiveListPtr'(1);
                pushCount = pushCount + 2'd1;
            end
        end
    end

    assign allocatable = count <= CountWidth'(Depth - `RENAME_WIDTH);
    assign empty = count == '0;
    assign popValid = commit && !empty;
    assign releaseValid = popValid && wrote[head];
    assign releaseReg = entries[head].phyPrevDstReg;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (pushTail[i]) begin
                entries[pushedPtr[i]] <= pushData[i];
                // A new register always differs from the one it replaces
                wrote[pushedPtr[i]] <= pushData[i].phyDstReg != pushData[i].phyPrevDstReg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= head + RenameTypes::ActiveListPtr'(popValid);
            tail <= tail + RenameTypes::ActiveListPtr'(pushCount);
            count <= count + CountWidth'(pushCount) - CountWidth'(popValid);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (pushCount != 2'd0) |-> (count + pushCount <= Depth))
        else $error("Active list overflow");

endmodule

/* logic/RenameCore.sv */
/*
 * Rename core
 * Two-wide rename subsystem: stage, map table with free list, active list
 */
`timescale 1ns/100ps
`include "rename_params.svh"

module RenameCore (
    input  logic clk,
    input  logic rst,
    input  logic [`RENAME_WIDTH-1:0] inValid,
    input  RenameTypes::OpInfo [`RENAME_WIDTH-1:0] inOp,
    input  logic stall,
    input  logic clear,
    input  logic commit,
    input  logic storeQueueEmpty,
    output logic ready,
    output logic [`RENAME_WIDTH-1:0] outValid,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhySrcA,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhySrcB,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhyDst,
    output RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhyPrevDst,
    output RenameTypes::ActiveListPtr [`RENAME_WIDTH-1:0] outActiveListPtr
);

    logic [`RENAME_WIDTH-1:0] pushTail;
    RenameTypes::ActiveListEntry [`RENAME_WIDTH-1:0] pushData;
    RenameTypes::ActiveListPtr [`RENAME_WIDTH-1:0] pushedPtr;
    logic alAllocatable;
    logic alEmpty;
    logic releaseValid;
    RenameTypes::PhyRegNum releaseReg;

    RenameLogicIF rnIf ();

    RenameStage stage (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inOp(inOp),
        .stall(stall),
        .clear(clear),
        .rn(rnIf.stage),
        .alAllocatable(alAllocatable),
        .alEmpty(alEmpty),
        .alPushedPtr(pushedPtr),
        .storeQueueEmpty(storeQueueEmpty),
        .pushTail(pushTail),
        .pushData(pushData),
        .ready(ready),
        .outValid(outValid),
        .outPhySrcA(outPhySrcA),
        .outPhySrcB(outPhySrcB),
        .outPhyDst(outPhyDst),
        .outPhyPrevDst(outPhyPrevDst),
        .outActiveListPtr(outActiveListPtr)
    );

    RenameLogic renameLogic (
        .clk(clk),
        .rst(rst),
        .rn(rnIf.renameLogic),
        .releaseValid(releaseValid),
        .releaseReg(releaseReg)
    );

    ActiveList activeList (
        .clk(clk),
        .rst(rst),
        .pushTail(pushTail),
        .pushData(pushData),
        .pushedPtr(pushedPtr),
        .allocatable(alAllocatable),
        .empty(alEmpty),
        .commit(commit),
        .releaseValid(releaseValid),
        .releaseReg(releaseReg)
    );

endmodule

/* test/RenameCoreTb.sv */
/*
 * Rename core testbench
 * Op groups from a table with expected ready and valid levels; a model of
 * map table, free list and active list predicts the renamed numbers
 */
`timescale 1ns/100ps
`include "rename_params.svh"

module RenameCoreTb;

    typedef struct packed {
        logic [7:0] cycles;
        logic [1:0] valid;
        RenameTypes::OpInfo op0;
        RenameTypes::OpInfo op1;
        logic stallIn;
        logic clearIn;
        logic commitIn;
        logic sqEmpty;
        logic expReady;
        logic [1:0] expValid;
    } StimRow;

    typedef struct packed {
        logic wrote;
        RenameTypes::PhyRegNum prevDst;
    } ModelEntry;

    logic clk;
    logic rst;
    logic [`RENAME_WIDTH-1:0] inValid;
    RenameTypes::OpInfo [`RENAME_WIDTH-1:0] inOp;
    logic stall;
    logic clear;
    logic commit;
    logic storeQueueEmpty;
    logic ready;
    logic [`RENAME_WIDTH-1:0] outValid;
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhySrcA;
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhySrcB;
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhyDst;
    RenameTypes::PhyRegNum [`RENAME_WIDTH-1:0] outPhyPrevDst;
    RenameTypes::ActiveListPtr [`RENAME_WIDTH-1:0] outActiveListPtr;

    StimRow rows [$];
    int totalCycles;
    logic tableDone;

    // Reference state
    int mapModel [`LOG_REG_NUM];
    int freeModel [$];
    ModelEntry activeModel [$];
    int tailModel;
    RenameTypes::OpInfo stageOp [`RENAME_WIDTH];

    RenameCore u_dut (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inOp(inOp),
        .stall(stall),
        .clear(clear),
        .commit(commit),
        .storeQueueEmpty(storeQueueEmpty),
        .ready(ready),
        .outValid(outValid),
        .outPhySrcA(outPhySrcA),
        .outPhySrcB(outPhySrcB),
        .outPhyDst(outPhyDst),
        .outPhyPrevDst(outPhyPrevDst),
        .outActiveListPtr(outActiveListPtr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic RenameTypes::OpInfo writeOp(int a, int b, int d);
        RenameTypes::OpInfo op;
        op = '0;
        op.srcRegA = RenameTypes::LogRegNum'(a);
        op.srcRegB = RenameTypes::LogRegNum'(b);
        op.dstReg = RenameTypes::LogRegNum'(d);
        op.readRegA = 1'b1;
        op.readRegB = 1'b1;
        op.writeReg = 1'b1;
        return op;
    endfunction

    function automatic RenameTypes::OpInfo serialOp(logic isFence);
        RenameTypes::OpInfo op;
        op = '0;
        op.serialized = 1'b1;
        op.fence = isFence;
        return op;
    endfunction

    task automatic addRow(int cycles, logic [1:0] valid, RenameTypes::OpInfo op0,
                          RenameTypes::OpInfo op1, logic stallIn, logic clearIn,
                          logic commitIn, logic sqEmpty, logic expReady,
                          logic [1:0] expValid);
        StimRow r;
        r = {8'(cycles), valid, op0, op1, stallIn, clearIn, commitIn, sqEmpty,
             expReady, expValid};
        rows.push_back(r);
        totalCycles += cycles;
    endtask

    task automatic checkValue(int actual, int expected, string what);
        if (actual != expected) begin
            $display("MISMATCH at time %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Run stopped at the first mismatch");
        end
    endtask

    task automatic buildTable();
        RenameTypes::OpInfo z;
        z = '0;
        // Allocation from the free list, bypass inside a group
        addRow(1, 2'b11, writeOp(1, 2, 3), writeOp(3, 4, 3), 0, 0, 0, 1, 1, 2'b00);
        addRow(1, 2'b11, writeOp(3, 5, 6), writeOp(6, 3, 7), 0, 0, 0, 1, 1, 2'b11);
        addRow(6, 2'b11, writeOp(7, 6, 8), writeOp(8, 8, 9), 0, 0, 0, 1, 1, 2'b11);
        addRow(1, 2'b11, writeOp(1, 3, 2), writeOp(2, 2, 4), 0, 0, 0, 1, 1, 2'b11);
        // Free list and active list run dry, two commits free two registers
        addRow(2, 2'b00, z, z, 0, 0, 0, 1, 0, 2'b00);
        addRow(2, 2'b00, z, z, 0, 0, 1, 1, 0, 2'b00);
        addRow(1, 2'b00, z, z, 0, 0, 0, 1, 1, 2'b11);
        // Serialized op waits for 16 older ops, then blocks the next group
        addRow(1, 2'b01, serialOp(0), z, 0, 0, 1, 1, 1, 2'b00);
        addRow(15, 2'b11, writeOp(9, 9, 10), writeOp(10, 1, 11), 0, 0, 1, 1, 0, 2'b00);
        addRow(1, 2'b11, writeOp(9, 9, 10), writeOp(10, 1, 11), 0, 0, 0, 1, 1, 2'b01);
        addRow(2, 2'b00, z, z, 0, 0, 0, 1, 0, 2'b00);
        addRow(1, 2'b00, z, z, 0, 0, 1, 1, 0, 2'b00);
        addRow(1, 2'b00, z, z, 0, 0, 0, 1, 1, 2'b11);
        // Fence held on a busy store queue
        addRow(1, 2'b01, serialOp(1), z, 0, 0, 1, 0, 1, 2'b00);
        addRow(1, 2'b00, z, z, 0, 0, 1, 0, 0, 2'b00);
        addRow(3, 2'b00, z, z, 0, 0, 0, 0, 0, 2'b00);
        addRow(1, 2'b00, z, z, 0, 0, 0, 1, 1, 2'b01);
        addRow(1, 2'b11, writeOp(11, 3, 12), writeOp(12, 12, 11), 0, 0, 1, 1, 0, 2'b00);
        addRow(1, 2'b11, writeOp(11, 3, 12), writeOp(12, 12, 11), 0, 0, 0, 1, 1, 2'b00);
        // External stall, then clear drops a group
        addRow(2, 2'b11, writeOp(13, 14, 15), writeOp(15, 13, 14), 1, 0, 0, 1, 0, 2'b00);
        addRow(1, 2'b11, writeOp(13, 14, 15), writeOp(15, 13, 14), 0, 0, 0, 1, 1, 2'b11);
        addRow(1, 2'b00, z, z, 0, 1, 0, 1, 1, 2'b00);
        addRow(1, 2'b00, z, z, 0, 0, 0, 1, 1, 2'b00);
        addRow(1, 2'b11, writeOp(13, 14, 15), writeOp(15, 13, 14), 0, 0, 0, 1, 1, 2'b00);
        addRow(1, 2'b00, z, z, 0, 0, 0, 1, 1, 2'b11);
        addRow(2, 2'b00, z, z, 0, 0, 0, 1, 1, 2'b00);
    endtask

    // Predicts the renamed slots, then applies the rising edge to the model
    task automatic renameAndCommit(StimRow r);
        int alBefore;
        int expDst;
        int expPrev;
        RenameTypes::OpInfo op;
        ModelEntry e;
        alBefore = activeModel.size();
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (r.expValid[i]) begin
                op = stageOp[i];
                expPrev = 0;
                if (op.readRegA)
                    checkValue(int'(outPhySrcA[i]), mapModel[op.srcRegA],
                               $sformatf("slot %0d source A", i));
                if (op.readRegB)
                    checkValue(int'(outPhySrcB[i]), mapModel[op.srcRegB],
                               $sformatf("slot %0d source B", i));
                if (op.writeReg) begin
                    expPrev = mapModel[op.dstReg];
                    expDst = freeModel.pop_front();
                    mapModel[op.dstReg] = expDst;
                    checkValue(int'(outPhyDst[i]), expDst, $sformatf("slot %0d dst", i));
                    checkValue(int'(outPhyPrevDst[i]), expPrev,
                               $sformatf("slot %0d previous dst", i));
                end
                checkValue(int'(outActiveListPtr[i]), tailModel,
                           $sformatf("slot %0d active-list pointer", i));
                tailModel = (tailModel + 1) % `ACTIVE_LIST_DEPTH;
                e.wrote = op.writeReg;
                e.prevDst = RenameTypes::PhyRegNum'(expPrev);
                activeModel.push_back(e);
            end
        end
        if (r.commitIn && alBefore > 0) begin
            e = activeModel.pop_front();
            if (e.wrote)
                freeModel.push_back(int'(e.prevDst));
        end
        if (r.expReady) begin
            stageOp[0] = r.op0;
            stageOp[1] = r.op1;
        end
    endtask

    initial begin
        rst = 1'b1;
        inValid = '0;
        inOp = '0;
        stall = 1'b0;
        clear = 1'b0;
        commit = 1'b0;
        storeQueueEmpty = 1'b1;
        totalCycles = 0;
        tableDone = 1'b0;
        // Identity map, upper registers free in ascending order
        for (int i = 0; i < `LOG_REG_NUM; i++)
            mapModel[i] = i;
        for (int i = `LOG_REG_NUM; i < `PHY_REG_NUM; i++)
            freeModel.push_back(i);
        tailModel = 0;
        buildTable();
        tableDone = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[k]) begin
            for (int c = 0; c < int'(rows[k].cycles); c++) begin
                @(negedge clk);
                inValid = rows[k].valid;
                inOp[0] = rows[k].op0;
                inOp[1] = rows[k].op1;
                stall = rows[k].stallIn;
                clear = rows[k].clearIn;
                commit = rows[k].commitIn;
                storeQueueEmpty = rows[k].sqEmpty;
                #2;
                checkValue(int'(ready), int'(rows[k].expReady), $sformatf("row %0d ready", k));
                checkValue(int'(outValid), int'(rows[k].expValid),
                           $sformatf("row %0d outValid", k));
                renameAndCommit(rows[k]);
            end
        end
        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial begin
        wait (tableDone);
        repeat (totalCycles * 20) @(posedge clk);
        $display("Timeout: the table did not finish within %0d cycles", totalCycles * 20);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* renameCore.f */
+incdir+common
common/RenameTypes.sv
common/RenameLogicIF.sv
rename/RenameStageSerializer.sv
rename/FreeList.sv
rename/RenameLogic.sv
rename/RenameStage.sv
logic/ActiveList.sv
logic/RenameCore.sv
test/RenameCoreTb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rename core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module RenameCoreTb -f renameCore.f -o simRenameCore

./obj_dir/simRenameCore 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
